// File: compile.f
src/pcs_pkg.sv
src/mac_rx_pkg.sv
src/block_decoder.sv
src/crc32_d64.sv
src/frame_checker.sv
src/rx_result.sv
src/baser_rx.sv
test/baser_rx_asserts.sv
test/tb_baser_rx.sv

// File: run.sh
#!/bin/sh
# build and run the frame receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_baser_rx -o sim_baser_rx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_baser_rx > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$log"; then
    exit 1
fi
exit 0

// File: src/baser_rx.sv
// 10GBASE-R frame receiver
`timescale 1ns/100ps

module baser_rx (
    input  logic                            clk,
    input  logic                            reset_crc,
    input  logic [pcs_pkg::data_w-1:0]      rx_data,
    input  logic [pcs_pkg::hdr_w-1:0]       rx_hdr,
    input  logic                            cfg_rx_enable,
    output logic [pcs_pkg::data_w-1:0]      rx_tdata,
    output logic [pcs_pkg::keep_w-1:0]      rx_tkeep,
    output logic                            rx_tvalid,
    output logic                            rx_tlast,
    output logic                            rx_tuser,
    output logic                            stat_pkt_good,
    output logic                            stat_pkt_bad,
    output logic                            stat_err_bad_fcs,
    output logic                            stat_err_framing,
    output logic [mac_rx_pkg::len_w-1:0]    stat_pkt_len,
    output logic                            stat_err_bad_block
);

    logic [pcs_pkg::data_w-1:0] dec_data;
    logic dec_start;
    logic dec_term;
    pcs_pkg::lane_t dec_term_lane;
    logic dec_framing_err;

    logic [pcs_pkg::data_w-1:0] ex_data;
    logic ex_valid;
    logic ex_last_pending;
    logic ex_end;
    pcs_pkg::lane_t ex_term_lane;
    logic ex_crc_ok;
    logic ex_framing;
    logic [mac_rx_pkg::len_w-1:0] ex_len;

    block_decoder decoder_i (
        .clk                (clk),
        .reset_crc          (reset_crc),
        .rx_data            (rx_data),
        .rx_hdr             (rx_hdr),
        .dec_data           (dec_data),
        .dec_start          (dec_start),
        .dec_term           (dec_term),
        .dec_term_lane      (dec_term_lane),
        .dec_framing_err    (dec_framing_err),
        .stat_err_bad_block (stat_err_bad_block)
    );

    frame_checker checker_i (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .cfg_rx_enable   (cfg_rx_enable),
        .dec_data        (dec_data),
        .dec_start       (dec_start),
        .dec_term        (dec_term),
        .dec_term_lane   (dec_term_lane),
        .dec_framing_err (dec_framing_err),
        .ex_data         (ex_data),
        .ex_valid        (ex_valid),
        .ex_last_pending (ex_last_pending),
        .ex_end          (ex_end),
        .ex_term_lane    (ex_term_lane),
        .ex_crc_ok       (ex_crc_ok),
        .ex_framing      (ex_framing),
        .ex_len          (ex_len)
    );

    rx_result result_i (
        .clk              (clk),
        .reset_crc        (reset_crc),
        .ex_data          (ex_data),
        .ex_valid         (ex_valid),
        .ex_last_pending  (ex_last_pending),
        .ex_end           (ex_end),
        .ex_term_lane     (ex_term_lane),
        .ex_crc_ok        (ex_crc_ok),
        .ex_framing       (ex_framing),
        .ex_len           (ex_len),
        .rx_tdata         (rx_tdata),
        .rx_tkeep         (rx_tkeep),
        .rx_tvalid        (rx_tvalid),
        .rx_tlast         (rx_tlast),
        .rx_tuser         (rx_tuser),
        .stat_pkt_good    (stat_pkt_good),
        .stat_pkt_bad     (stat_pkt_bad),
        .stat_err_bad_fcs (stat_err_bad_fcs),
        .stat_err_framing (stat_err_framing),
        .stat_pkt_len     (stat_pkt_len)
    );

endmodule

// File: src/block_decoder.sv
// 64b/66b block decoder
`timescale 1ns/100ps

module block_decoder (
    input  logic                        clk,
    input  logic                        reset_crc,
    input  logic [pcs_pkg::data_w-1:0]  rx_data,
    input  logic [pcs_pkg::hdr_w-1:0]   rx_hdr,
    output logic [pcs_pkg::data_w-1:0]  dec_data,
    output logic                        dec_start,
    output logic                        dec_term,
    output pcs_pkg::lane_t              dec_term_lane,
    output logic                        dec_framing_err,
    output logic                        stat_err_bad_block
);

    pcs_pkg::block_type_e blk_type;
    pcs_pkg::lane_t term_lane;
    logic [pcs_pkg::data_w-1:0] data_masked;
    logic is_data;
    logic is_ctrl;
    logic legal_type;
    logic is_start;
    logic is_term;
    logic in_frame;

    always_comb begin
        blk_type = pcs_pkg::block_type_e'(rx_data[7:0]);
        is_data = rx_hdr == pcs_pkg::sync_data;
        is_ctrl = rx_hdr == pcs_pkg::sync_ctrl;
        legal_type = 1'b1;
        is_start = 1'b0;
        is_term = 1'b0;
        term_lane = '0;
        case (blk_type)
            pcs_pkg::blk_start_0: is_start = 1'b1;
            pcs_pkg::blk_term_0: is_term = 1'b1;
            pcs_pkg::blk_term_1: {is_term, term_lane} = {1'b1, 3'd1};
            pcs_pkg::blk_term_2: {is_term, term_lane} = {1'b1, 3'd2};
            pcs_pkg::blk_term_3: {is_term, term_lane} = {1'b1, 3'd3};
            pcs_pkg::blk_term_4: {is_term, term_lane} = {1'b1, 3'd4};
            pcs_pkg::blk_term_5: {is_term, term_lane} = {1'b1, 3'd5};
            pcs_pkg::blk_term_6: {is_term, term_lane} = {1'b1, 3'd6};
            pcs_pkg::blk_term_7: {is_term, term_lane} = {1'b1, 3'd7};
            // legal but never start a frame here
            pcs_pkg::blk_ctrl,
            pcs_pkg::blk_os_4,
            pcs_pkg::blk_start_4,
            pcs_pkg::blk_os_start,
            pcs_pkg::blk_os_04,
            pcs_pkg::blk_os_0: legal_type = 1'b1;
            default: legal_type = 1'b0;
        endcase

        // terminate: drop the type octet, keep only the data bytes
        data_masked = rx_data;
        if (is_ctrl && is_term) begin
            data_masked = (rx_data >> 8) & ~({pcs_pkg::data_w{1'b1}} << {term_lane, 3'b000});
        end
    end

    always_ff @(posedge clk) begin
        dec_data <= data_masked;
        dec_term_lane <= term_lane;
        if (reset_crc) begin
            in_frame <= 1'b0;
            dec_start <= 1'b0;
            dec_term <= 1'b0;
            dec_framing_err <= 1'b0;
            stat_err_bad_block <= 1'b0;
        end else begin
            dec_start <= is_ctrl && is_start;
            dec_term <= is_ctrl && is_term;
            stat_err_bad_block <= !is_data && !(is_ctrl && legal_type);
            if (is_data) begin
                dec_framing_err <= !in_frame;
            end else if (is_ctrl && is_term) begin
                dec_framing_err <= !in_frame;
                in_frame <= 1'b0;
            end else begin
                // any other block, including bad ones, breaks a running frame
                dec_framing_err <= in_frame;
                in_frame <= is_ctrl && is_start;
            end
        end
    end

endmodule

// File: src/crc32_d64.sv
// CRC-32 over one 64-bit word
`timescale 1ns/100ps

module crc32_d64 (
    input  logic [31:0]                 state_in,
    input  logic [pcs_pkg::data_w-1:0]  data_in,
    output logic [31:0]                 state_out,
    output logic [pcs_pkg::keep_w-1:0]  lane_ok
);

    logic [31:0] poly_r;
    logic [31:0] crc;

    always_comb begin
        // reflected form, bits go in lsb first
        for (int i = 0; i < 32; i++) begin
            poly_r[i] = mac_rx_pkg::crc_poly[31-i];
        end

        crc = state_in;
        for (int b = 0; b < pcs_pkg::keep_w; b++) begin
            for (int i = 0; i < 8; i++) begin
                if (crc[0] ^ data_in[8*b+i]) begin
                    crc = (crc >> 1) ^ poly_r;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        state_out = crc;
    end

    // one compare per possible end byte of the fcs
    always_comb begin
        for (int k = 0; k < pcs_pkg::keep_w; k++) begin
            lane_ok[k] = state_out == mac_rx_pkg::crc_residue[k];
        end
    end

endmodule

// File: src/frame_checker.sv
// Receive frame state machine and CRC check
`timescale 1ns/100ps

module frame_checker (
    input  logic                            clk,
    input  logic                            reset_crc,
    input  logic                            cfg_rx_enable,
    input  logic [pcs_pkg::data_w-1:0]      dec_data,
    input  logic                            dec_start,
    input  logic                            dec_term,
    input  pcs_pkg::lane_t                  dec_term_lane,
    input  logic                            dec_framing_err,
    output logic [pcs_pkg::data_w-1:0]      ex_data,
    output logic                            ex_valid,
    output logic                            ex_last_pending,
    output logic                            ex_end,
    output pcs_pkg::lane_t                  ex_term_lane,
    output logic                            ex_crc_ok,
    output logic                            ex_framing,
    output logic [mac_rx_pkg::len_w-1:0]    ex_len
);

    typedef logic [mac_rx_pkg::len_w-1:0] len_t;

    mac_rx_pkg::rx_state_e state, state_next;
    logic crc_restart;
    logic [31:0] crc_state;
    logic [31:0] crc_next;
    logic [pcs_pkg::keep_w-1:0] lane_ok;
    logic [pcs_pkg::keep_w-1:0] lane_ok_save;
    logic start_d1;
    logic framing_d1;
    pcs_pkg::lane_t term_lane_d1;
    pcs_pkg::lane_t pay_idx;
    pcs_pkg::lane_t last_idx;
    len_t len_reg, len_next;

    // crc runs on the decoder word, one block ahead of ex_data
    crc32_d64 crc_i (
        .state_in  (crc_state),
        .data_in   (dec_data),
        .state_out (crc_next),
        .lane_ok   (lane_ok)
    );

    always_comb begin
        // lane 0 wraps to 7, which selects the saved full-word compare
        pay_idx = dec_term_lane - 3'd1;
        last_idx = term_lane_d1 - 3'd1;

        state_next = state;
        crc_restart = 1'b0;
        len_next = len_reg;
        ex_valid = 1'b0;
        ex_last_pending = 1'b0;
        ex_end = 1'b0;
        ex_framing = 1'b0;
        ex_crc_ok = 1'b0;
        ex_term_lane = dec_term_lane;
        ex_len = len_reg;

        case (state)
            mac_rx_pkg::st_idle: begin
                crc_restart = 1'b1;
                len_next = len_t'(pcs_pkg::keep_w);
                if (start_d1 && cfg_rx_enable) begin
                    crc_restart = 1'b0;
                    state_next = mac_rx_pkg::st_payload;
                end
            end
            mac_rx_pkg::st_payload: begin
                ex_valid = 1'b1;
                if (dec_term) begin
                    len_next = len_reg + len_t'(dec_term_lane);
                end else begin
                    len_next = len_reg + len_t'(pcs_pkg::keep_w);
                end
                ex_len = len_next;

                if (dec_framing_err || framing_d1) begin
                    ex_end = 1'b1;
                    ex_framing = 1'b1;
                    crc_restart = 1'b1;
                    state_next = mac_rx_pkg::st_idle;
                end else if (dec_term && dec_term_lane <= mac_rx_pkg::fcs_bytes) begin
                    // fcs tail fits in this block, current beat is the last one
                    ex_end = 1'b1;
                    if (dec_term_lane == 0) begin
                        ex_crc_ok = lane_ok_save[pay_idx];
                    end else begin
                        ex_crc_ok = lane_ok[pay_idx];
                    end
                    crc_restart = 1'b1;
                    state_next = mac_rx_pkg::st_idle;
                end else if (dec_term) begin
                    state_next = mac_rx_pkg::st_last;
                end
            end
            mac_rx_pkg::st_last: begin
                ex_valid = 1'b1;
                ex_last_pending = 1'b1;
                ex_end = 1'b1;
                ex_term_lane = term_lane_d1;
                ex_crc_ok = lane_ok_save[last_idx];
                crc_restart = 1'b1;
                state_next = mac_rx_pkg::st_idle;
            end
            default: state_next = mac_rx_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_data <= dec_data;
        term_lane_d1 <= dec_term_lane;
        lane_ok_save <= lane_ok;
        if (reset_crc || crc_restart) begin
            crc_state <= mac_rx_pkg::crc_init;
        end else begin
            crc_state <= crc_next;
        end
        if (reset_crc) begin
            state <= mac_rx_pkg::st_idle;
            start_d1 <= 1'b0;
            framing_d1 <= 1'b0;
            len_reg <= '0;
        end else begin
            state <= state_next;
            start_d1 <= dec_start;
            framing_d1 <= dec_framing_err;
            len_reg <= len_next;
        end
    end

endmodule

// File: src/mac_rx_pkg.sv
// Ethernet receive definitions
package mac_rx_pkg;

    // frame state
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_payload = 2'd1,
        st_last    = 2'd2
    } rx_state_e;

    // crc-32, normal form of the polynomial
    localparam logic [31:0] crc_poly = 32'h04c11db7;
    localparam logic [31:0] crc_init = 32'hffffffff;

    // expected crc state when the fcs ends at byte k of an 8 byte word,
    // bytes above k are zero padding from the terminate mask
    localparam logic [7:0][31:0] crc_residue = {
        32'hdebb20e3,
        32'h39dd08e2,
        32'h4e3d5e5c,
        32'h62932081,
        32'h9add2096,
        32'h19f6eb51,
        32'h1c759789,
        32'h94784e13
    };

    // frame length counter
    localparam int len_w = 16;

    // trailing fcs
    localparam int fcs_bytes = 4;

endpackage

// File: src/pcs_pkg.sv
// 64b/66b block definitions
package pcs_pkg;

    // block geometry
    localparam int data_w = 64;
    localparam int keep_w = data_w / 8;
    localparam int hdr_w = 2;
    localparam int lane_w = $clog2(keep_w);

    // sync header values
    localparam logic [hdr_w-1:0] sync_data = 2'b10;
    localparam logic [hdr_w-1:0] sync_ctrl = 2'b01;

    // legal control block types, first octet of the payload
    typedef enum logic [7:0] {
        blk_ctrl     = 8'h1e,
        blk_os_4     = 8'h2d,
        blk_start_4  = 8'h33,
        blk_os_start = 8'h66,
        blk_os_04    = 8'h55,
        blk_start_0  = 8'h78,
        blk_os_0     = 8'h4b,
        blk_term_0   = 8'h87,
        blk_term_1   = 8'h99,
        blk_term_2   = 8'haa,
        blk_term_3   = 8'hb4,
        blk_term_4   = 8'hcc,
        blk_term_5   = 8'hd2,
        blk_term_6   = 8'he1,
        blk_term_7   = 8'hff
    } block_type_e;

    // byte lane within a block
    typedef logic [lane_w-1:0] lane_t;

endpackage

// File: src/rx_result.sv
// Output beat and status register stage
`timescale 1ns/100ps

module rx_result (
    input  logic                            clk,
    input  logic                            reset_crc,
    input  logic [pcs_pkg::data_w-1:0]      ex_data,
    input  logic                            ex_valid,
    input  logic                            ex_last_pending,
    input  logic                            ex_end,
    input  pcs_pkg::lane_t                  ex_term_lane,
    input  logic                            ex_crc_ok,
    input  logic                            ex_framing,
    input  logic [mac_rx_pkg::len_w-1:0]    ex_len,
    output logic [pcs_pkg::data_w-1:0]      rx_tdata,
    output logic [pcs_pkg::keep_w-1:0]      rx_tkeep,
    output logic                            rx_tvalid,
    output logic                            rx_tlast,
    output logic                            rx_tuser,
    output logic                            stat_pkt_good,
    output logic                            stat_pkt_bad,
    output logic                            stat_err_bad_fcs,
    output logic                            stat_err_framing,
    output logic [mac_rx_pkg::len_w-1:0]    stat_pkt_len
);

    logic [3:0] keep_bytes;
    logic [pcs_pkg::keep_w-1:0] keep_next;
    logic bad;

    always_comb begin
        // bytes left in the last beat once the fcs is stripped
        if (ex_last_pending) begin
            keep_bytes = {1'b0, ex_term_lane} - 4'(mac_rx_pkg::fcs_bytes);
        end else begin
            keep_bytes = {1'b0, ex_term_lane} + 4'(pcs_pkg::keep_w - mac_rx_pkg::fcs_bytes);
        end

        if (!ex_valid) begin
            keep_next = '0;
        end else if (ex_end && !ex_framing) begin
            keep_next = ~({pcs_pkg::keep_w{1'b1}} << keep_bytes);
        end else begin
            keep_next = '1;
        end

        bad = ex_framing || !ex_crc_ok;
    end

    always_ff @(posedge clk) begin
        rx_tdata <= ex_data;
        rx_tkeep <= keep_next;
        if (reset_crc) begin
            rx_tvalid <= 1'b0;
            rx_tlast <= 1'b0;
            rx_tuser <= 1'b0;
            stat_pkt_good <= 1'b0;
            stat_pkt_bad <= 1'b0;
            stat_err_bad_fcs <= 1'b0;
            stat_err_framing <= 1'b0;
            stat_pkt_len <= '0;
        end else begin
            rx_tvalid <= ex_valid;
            rx_tlast <= ex_end;
            rx_tuser <= ex_end && bad;
            stat_pkt_good <= ex_end && !bad;
            stat_pkt_bad <= ex_end && bad;
            stat_err_bad_fcs <= ex_end && !ex_framing && !ex_crc_ok;
            stat_err_framing <= ex_end && ex_framing;
            stat_pkt_len <= ex_end ? ex_len : '0;
        end
    end

endmodule

// File: test/baser_rx_asserts.sv
// Output stream assertions
`timescale 1ns/100ps

module baser_rx_asserts (
    input logic clk,
    input logic reset_crc,
    input logic rx_tvalid,
    input logic rx_tlast,
    input logic rx_tuser,
    input logic stat_pkt_good,
    input logic stat_pkt_bad
);

    // a last beat is always a valid beat
    last_is_valid: assert property (@(posedge clk) disable iff (reset_crc)
        rx_tlast |-> rx_tvalid)
        else $error("rx_tlast high while rx_tvalid low");

    // error flag only on the closing beat
    user_on_last: assert property (@(posedge clk) disable iff (reset_crc)
        rx_tuser |-> rx_tlast)
        else $error("rx_tuser high outside a last beat");

    good_or_bad: assert property (@(posedge clk) disable iff (reset_crc)
        !(stat_pkt_good && stat_pkt_bad))
        else $error("stat_pkt_good and stat_pkt_bad in the same cycle");

    // stream is quiet once reset has been seen
    quiet_after_reset: assert property (@(posedge clk) reset_crc |=> !rx_tvalid)
        else $error("rx_tvalid high right after reset");

endmodule

bind baser_rx baser_rx_asserts asserts_i (
    .clk           (clk),
    .reset_crc     (reset_crc),
    .rx_tvalid     (rx_tvalid),
    .rx_tlast      (rx_tlast),
    .rx_tuser      (rx_tuser),
    .stat_pkt_good (stat_pkt_good),
    .stat_pkt_bad  (stat_pkt_bad)
);

// File: test/tb_baser_rx.sv
// Frame receiver testbench
`timescale 1ns/100ps

module tb_baser_rx;

    localparam logic [1:0] hdr_data = 2'b10;
    localparam logic [1:0] hdr_ctrl = 2'b01;
    localparam logic [63:0] idle_blk = 64'h1e;
    // start in lane 0, six preamble octets and the SFD
    localparam logic [63:0] start_blk = 64'hd555555555555578;
    // terminate type octet, indexed by the data bytes it carries
    localparam logic [7:0][7:0] term_code = {
        8'hff, 8'he1, 8'hd2, 8'hcc, 8'hb4, 8'haa, 8'h99, 8'h87
    };
    localparam int k_good = 0;
    localparam int k_bad_fcs = 1;
    localparam int k_framing = 2;
    localparam int k_bad_hdr = 3;
    localparam int k_bad_type = 4;
    localparam int n_tests = 15;
    // data blocks sent before the stray idle
    localparam int cut_blocks = 3;

    typedef struct packed {
        int pay_len;
        int kind;
        logic enable;
        logic exp_good;
        logic exp_fcs_err;
        logic exp_framing;
        int exp_bad_blocks;
    } test_t;

    logic clk;
    logic reset_crc;
    logic [63:0] rx_data;
    logic [1:0] rx_hdr;
    logic cfg_rx_enable;
    logic [63:0] rx_tdata;
    logic [7:0] rx_tkeep;
    logic rx_tvalid, rx_tlast, rx_tuser;
    logic stat_pkt_good, stat_pkt_bad, stat_err_bad_fcs, stat_err_framing;
    logic [15:0] stat_pkt_len;
    logic stat_err_bad_block;

    test_t tests [n_tests];
    int seed = 32'h92778979;
    logic table_ready = 1'b0;
    logic [7:0] frame_q [$];
    logic [63:0] blk_data_q [$];
    logic [1:0] blk_hdr_q [$];
    // {tuser, tlast, tkeep, tdata}
    logic [73:0] got_q [$];
    int n_good, n_bad, n_fcs, n_framing, n_bad_blk, got_len;
    int failed = 0;

    baser_rx dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic load_table();
        // payload, kind, enable, good, bad fcs, framing, bad blocks
        tests[0] = '{60, k_good, 1'b1, 1'b1, 1'b0, 1'b0, 0};
        tests[1] = '{61, k_good, 1'b1, 1'b1, 1'b0, 1'b0, 0};
        tests[2] = '{62, k_good, 1'b1, 1'b1, 1'b0, 1'b0, 0};
        tests[3] = '{63, k_good, 1'b1, 1'b1, 1'b0, 1'b0, 0};
        tests[4] = '{64, k_good, 1'b1, 1'b1, 1'b0, 1'b0, 0};
        tests[5] = '{65, k_good, 1'b1, 1'b1, 1'b0, 1'b0, 0};
        tests[6] = '{66, k_good, 1'b1, 1'b1, 1'b0, 1'b0, 0};
        tests[7] = '{67, k_good, 1'b1, 1'b1, 1'b0, 1'b0, 0};
        tests[8] = '{64, k_bad_fcs, 1'b1, 1'b0, 1'b1, 1'b0, 0};
        tests[9] = '{67, k_bad_fcs, 1'b1, 1'b0, 1'b1, 1'b0, 0};
        tests[10] = '{46, k_framing, 1'b1, 1'b0, 1'b0, 1'b1, 0};
        tests[11] = '{50, k_bad_hdr, 1'b1, 1'b1, 1'b0, 1'b0, 1};
        tests[12] = '{70, k_bad_type, 1'b1, 1'b1, 1'b0, 1'b0, 1};
        tests[13] = '{60, k_good, 1'b0, 1'b0, 1'b0, 1'b0, 0};
        tests[14] = '{100, k_good, 1'b1, 1'b1, 1'b0, 1'b0, 0};
    endtask

    // Ethernet FCS over frame_q, reflected, sent low byte first
    function automatic logic [31:0] crc_model();
        logic [31:0] c;
        c = 32'hffffffff;
        foreach (frame_q[i]) begin
            c = c ^ {24'h0, frame_q[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic build_frame(input test_t t);
        logic [31:0] fcs;
        logic [63:0] d;
        logic [1:0] h;
        int n;
        frame_q.delete();
        blk_data_q.delete();
        blk_hdr_q.delete();
        for (int i = 0; i < t.pay_len; i++) begin
            frame_q.push_back(8'($random(seed)));
        end
        fcs = crc_model();
        if (t.kind == k_bad_fcs) begin
            fcs = fcs ^ (32'h1 << 5'($random(seed)));
        end
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(fcs[8*i +: 8]);
        end
        n = frame_q.size();
        blk_data_q.push_back(start_blk);
        blk_hdr_q.push_back(hdr_ctrl);
        for (int i = 0; i + 8 <= n; i += 8) begin
            if (t.kind != k_framing || i < 8 * cut_blocks) begin
                for (int j = 0; j < 8; j++) begin
                    d[8*j +: 8] = frame_q[i + j];
                end
                blk_data_q.push_back(d);
                blk_hdr_q.push_back(hdr_data);
            end
        end
        // a framing test never sends its terminate
        if (t.kind != k_framing) begin
            d = {{7{8'h07}}, term_code[n % 8]};
            for (int j = 0; j < n % 8; j++) begin
                d[8*j+8 +: 8] = frame_q[n - n % 8 + j];
            end
            blk_data_q.push_back(d);
            blk_hdr_q.push_back(hdr_ctrl);
        end
        // inter-frame gap, bad blocks land here
        for (int i = 0; i < 6; i++) begin
            d = idle_blk;
            h = hdr_ctrl;
            if (i == 2 && t.kind == k_bad_hdr) begin
                h = 2'b00;
            end
            if (i == 2 && t.kind == k_bad_type) begin
                d = 64'h0;
            end
            blk_data_q.push_back(d);
            blk_hdr_q.push_back(h);
        end
    endtask

    // sample what the last rising edge produced, then drive the next block
    task automatic step(input logic [63:0] d, input logic [1:0] h);
        @(negedge clk);
        if (rx_tvalid) begin
            got_q.push_back({rx_tuser, rx_tlast, rx_tkeep, rx_tdata});
        end
        n_good += 32'(stat_pkt_good);
        n_bad += 32'(stat_pkt_bad);
        n_fcs += 32'(stat_err_bad_fcs);
        n_framing += 32'(stat_err_framing);
        n_bad_blk += 32'(stat_err_bad_block);
        if (stat_pkt_good || stat_pkt_bad) begin
            got_len = 32'(stat_pkt_len);
        end
        rx_data = d;
        rx_hdr = h;
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp, inout int errs);
        if (got != exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            errs++;
        end
    endtask

    task automatic score_test(input test_t t, output int errs);
        logic [73:0] g;
        logic [7:0] keep;
        logic [63:0] exp_d;
        logic [63:0] mask;
        logic last;
        int nbytes;
        int beats;
        errs = 0;
        nbytes = t.kind == k_framing ? 8 * cut_blocks : t.pay_len;
        beats = t.enable ? (nbytes + 7) / 8 : 0;
        if (got_q.size() != beats) begin
            $display("received %0d beats where %0d were expected", got_q.size(), beats);
            errs++;
        end else begin
            for (int b = 0; b < beats; b++) begin
                g = got_q[b];
                last = b == beats - 1;
                keep = 8'hff;
                if (last && t.kind != k_framing) begin
                    keep = 8'hff >> (7 - (nbytes - 1) % 8);
                end
                exp_d = '0;
                mask = '0;
                for (int j = 0; j < 8; j++) begin
                    if (keep[j]) begin
                        exp_d[8*j +: 8] = frame_q[8*b + j];
                        mask[8*j +: 8] = 8'hff;
                    end
                end
                compare_field("rx_tdata", g[63:0] & mask, exp_d, errs);
                compare_field("rx_tkeep", 64'(g[71:64]), 64'(keep), errs);
                compare_field("rx_tlast", 64'(g[72]), 64'(last), errs);
                compare_field("rx_tuser", 64'(g[73]), 64'(last && !t.exp_good), errs);
            end
        end
        compare_field("stat_pkt_good", 64'(n_good), 64'(t.enable && t.exp_good), errs);
        compare_field("stat_pkt_bad", 64'(n_bad), 64'(t.enable && !t.exp_good), errs);
        compare_field("stat_err_bad_fcs", 64'(n_fcs), 64'(t.enable && t.exp_fcs_err), errs);
        compare_field("stat_err_framing", 64'(n_framing), 64'(t.enable && t.exp_framing),
                      errs);
        compare_field("stat_err_bad_block", 64'(n_bad_blk), 64'(t.exp_bad_blocks), errs);
        if (t.enable && !t.exp_framing) begin
            compare_field("stat_pkt_len", 64'(got_len), 64'(t.pay_len + 4), errs);
        end
    endtask

    // watchdog, budget grows with the frame lengths in the table
    initial begin
        int budget;
        wait (table_ready);
        budget = 40;
        foreach (tests[i]) begin
            budget += tests[i].pay_len / 8 + 24;
        end
        repeat (budget) @(posedge clk);
        $display("timeout after %0d cycles, frame status never arrived", budget);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int errs;
        int reset_errs;
        reset_crc = 1'b1;
        rx_data = idle_blk;
        rx_hdr = hdr_ctrl;
        cfg_rx_enable = 1'b1;
        load_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_crc = 1'b0;

        reset_errs = 0;
        repeat (4) begin
            step(idle_blk, hdr_ctrl);
            if (rx_tvalid || rx_tlast || rx_tuser || stat_pkt_good || stat_pkt_bad
                    || stat_err_bad_fcs || stat_err_framing || stat_err_bad_block
                    || stat_pkt_len != 0) begin
                $display("outputs not quiet right after reset");
                reset_errs++;
            end
        end
        $display("reset check: %s", reset_errs == 0 ? "ok" : "mismatch");
        failed += 32'(reset_errs != 0);

        foreach (tests[i]) begin
            build_frame(tests[i]);
            got_q.delete();
            n_good = 0;
            n_bad = 0;
            n_fcs = 0;
            n_framing = 0;
            n_bad_blk = 0;
            got_len = 0;
            cfg_rx_enable = tests[i].enable;
            foreach (blk_data_q[b]) begin
                step(blk_data_q[b], blk_hdr_q[b]);
            end
            while (tests[i].enable && n_good + n_bad == 0) begin
                step(idle_blk, hdr_ctrl);
            end
            // drain, catches stray beats or pulses
            repeat (4) begin
                step(idle_blk, hdr_ctrl);
            end
            score_test(tests[i], errs);
            $display("test %0d: payload %0d kind %0d enable %0b: %s", i, tests[i].pay_len,
                     tests[i].kind, tests[i].enable, errs == 0 ? "ok" : "mismatch");
            failed += 32'(errs != 0);
        end

        $display("summary: %0d tests run, %0d ok, %0d with mismatches", n_tests + 1,
                 n_tests + 1 - failed, failed);
        if (failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
